/* rtl/haar_geom_pkg.sv */
package haar_geom_pkg;

	// detection window, one stage looks at 10 x 10 pixels
	localparam int WINDOW_W = 10;
	localparam int WINDOW_H = 10;
	localparam int WINDOW_PIXELS = WINDOW_W * WINDOW_H;

	// raw pixel, unsigned greyscale
	localparam int PIXEL_W = 8;

	// summed-area table entry, unsigned
	// worst case is 100 * 255 = 25500
	localparam int INTEG_W = 16;

	// flat table index r * WINDOW_W + c
	localparam int INDEX_W = $clog2(WINDOW_PIXELS);

	// entry r * WINDOW_W + c holds the sum over rows <= r and columns <= c
	// so a rectangle needs corner A outside it, row 0 and column 0 never inside

endpackage

/* rtl/haar_cascade_pkg.sv */
package haar_cascade_pkg;

	// one stage of the cascade
	localparam int NUM_FEATURES = 4;
	localparam int RECTS = 3;      // rectangles per feature
	localparam int CORNERS = 4;    // A, B, C, D in that order

	// corner slots inside a rectangle
	localparam int CORNER_A = 0;
	localparam int CORNER_B = 1;
	localparam int CORNER_C = 2;
	localparam int CORNER_D = 3;

	// signed formats
	localparam int WEIGHT_W = 8;
	// rect sum needs 18 bits signed, times weight 26, three of them 28
	localparam int FEATURE_W = 28;
	localparam int VOTE_W = 16;
	// four votes of 16 bits never overflow 18
	localparam int STAGE_W = 18;

endpackage

/* rtl/integral_image_builder.sv */
`timescale 1ns/100ps

module integral_image_builder
(
	input	logic	calculate,
	input	logic	rst_n,
	input	logic	pixel_valid,
	input	logic	[haar_geom_pkg::PIXEL_W-1:0] pixel,
	output	logic	[haar_geom_pkg::INTEG_W-1:0] integral [haar_geom_pkg::WINDOW_PIXELS],
	output	logic	image_ready
);
	import haar_geom_pkg::*;

	logic [$clog2(WINDOW_W)-1:0] col;
	logic [$clog2(WINDOW_H)-1:0] row;
	logic [INTEG_W-1:0] row_sum;       // pixels of this row left of col
	logic [INTEG_W-1:0] row_sum_next;
	logic [INTEG_W-1:0] above;
	logic [INDEX_W-1:0] pos;
	logic [INDEX_W-1:0] pos_up;

	assign row_sum_next = row_sum + INTEG_W'(pixel);
	assign pos = INDEX_W'(row * WINDOW_W + col);
	assign pos_up = pos - INDEX_W'(WINDOW_W);

	// entry one row up, nothing above row 0
	always_comb
	begin
		above = '0;
		if (row != '0)
			above = integral[pos_up];
	end

	always_ff @(posedge calculate or negedge rst_n)
	begin
		if (!rst_n)
		begin
			col <= '0;
			row <= '0;
			row_sum <= '0;
			image_ready <= 1'b0;
		end
		else
		begin
			image_ready <= 1'b0;
			if (pixel_valid)
			begin
				if (col == WINDOW_W - 1)
				begin
					col <= '0;
					row_sum <= '0;
					if (row == WINDOW_H - 1)
					begin
						row <= '0;
						image_ready <= 1'b1;   // last pixel of the frame
					end
					else
						row <= row + 1'b1;
				end
				else
				begin
					col <= col + 1'b1;
					row_sum <= row_sum_next;
				end
			end
		end
	end

	// the evaluators sample on the image_ready edge, a write of
	// entry 0 on that same edge is seen only afterwards
	always_ff @(posedge calculate)
	begin
		if (pixel_valid)
			integral[pos] <= row_sum_next + above;
	end

	counters_in_window: assert property (@(posedge calculate) disable iff (!rst_n)
		(col < WINDOW_W) && (row < WINDOW_H));

endmodule

/* rtl/haar_feature_eval.sv */
`timescale 1ns/100ps

module haar_feature_eval
(
	input	logic	calculate,
	input	logic	rst_n,
	input	logic	eval_start,
	input	logic	[haar_geom_pkg::INTEG_W-1:0] integral [haar_geom_pkg::WINDOW_PIXELS],
	input	logic	[haar_cascade_pkg::RECTS-1:0][haar_cascade_pkg::CORNERS-1:0]
			[haar_geom_pkg::INDEX_W-1:0] corner_index,
	input	logic	[haar_cascade_pkg::RECTS-1:0][haar_cascade_pkg::WEIGHT_W-1:0] rect_weight,
	input	logic	signed [haar_cascade_pkg::FEATURE_W-1:0] feature_threshold,
	input	logic	[haar_cascade_pkg::VOTE_W-1:0] left_word,
	input	logic	[haar_cascade_pkg::VOTE_W-1:0] right_word,
	output	logic	feature_valid,
	output	logic	[haar_cascade_pkg::VOTE_W-1:0] vote
);
	import haar_geom_pkg::*;
	import haar_cascade_pkg::*;

	logic [INTEG_W-1:0] corner_q [RECTS][CORNERS];
	logic signed [WEIGHT_W-1:0] weight_q [RECTS];
	logic signed [INTEG_W+1:0] rect_sum [RECTS];
	logic signed [FEATURE_W-1:0] weighted [RECTS];
	logic signed [FEATURE_W-1:0] feature_sum;
	logic signed [FEATURE_W-1:0] feature_q;
	logic s1_valid;
	logic s2_valid;
	logic index_ok;

	// valid bits walk alongside the data
	always_ff @(posedge calculate or negedge rst_n)
	begin
		if (!rst_n)
		begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			feature_valid <= 1'b0;
		end
		else
		begin
			s1_valid <= eval_start;
			s2_valid <= s1_valid;
			feature_valid <= s2_valid;
		end
	end

	// stage 1, fetch the twelve corners
	always_ff @(posedge calculate)
	begin
		if (eval_start)
		begin
			for (int r = 0; r < RECTS; r++)
			begin
				for (int c = 0; c < CORNERS; c++)
					corner_q[r][c] <= integral[corner_index[r][c]];
				weight_q[r] <= $signed(rect_weight[r]);
			end
		end
	end

	// A + D - B - C, then weight
	always_comb
	begin
		feature_sum = '0;
		for (int r = 0; r < RECTS; r++)
		begin
			rect_sum[r] = $signed({2'b00, corner_q[r][CORNER_A]})
				+ $signed({2'b00, corner_q[r][CORNER_D]})
				- $signed({2'b00, corner_q[r][CORNER_B]})
				- $signed({2'b00, corner_q[r][CORNER_C]});
			weighted[r] = rect_sum[r] * weight_q[r];
			feature_sum = feature_sum + weighted[r];
		end
	end

	// stage 2 and 3
	always_ff @(posedge calculate)
	begin
		if (s1_valid)
			feature_q <= feature_sum;
		if (s2_valid)
			vote <= (feature_q > feature_threshold) ? right_word : left_word;   // strict
	end

	always_comb
	begin
		index_ok = 1'b1;
		for (int r = 0; r < RECTS; r++)
			for (int c = 0; c < CORNERS; c++)
				if (corner_index[r][c] >= WINDOW_PIXELS)
					index_ok = 1'b0;
	end

	corners_in_table: assert property (@(posedge calculate) disable iff (!rst_n)
		eval_start |-> index_ok);

endmodule

/* rtl/stage_vote_sum.sv */
`timescale 1ns/100ps

module stage_vote_sum
(
	input	logic	calculate,
	input	logic	rst_n,
	input	logic	[haar_cascade_pkg::NUM_FEATURES-1:0] feature_valid,
	input	logic	[haar_cascade_pkg::NUM_FEATURES-1:0][haar_cascade_pkg::VOTE_W-1:0] vote,
	input	logic	signed [haar_cascade_pkg::STAGE_W-1:0] stage_threshold,
	output	logic	stage_valid,
	output	logic	stage_pass,
	output	logic	signed [haar_cascade_pkg::STAGE_W-1:0] stage_sum
);
	import haar_cascade_pkg::*;

	logic signed [STAGE_W-1:0] vote_total;

	always_comb
	begin
		vote_total = '0;
		for (int f = 0; f < NUM_FEATURES; f++)
			vote_total = vote_total + STAGE_W'($signed(vote[f]));   // sign extend
	end

	always_ff @(posedge calculate or negedge rst_n)
	begin
		if (!rst_n)
			stage_valid <= 1'b0;
		else
			stage_valid <= &feature_valid;
	end

	always_ff @(posedge calculate)
	begin
		if (&feature_valid)
		begin
			stage_sum <= vote_total;
			stage_pass <= vote_total >= stage_threshold;
		end
	end

	// all evaluators share one start pulse and one latency
	features_in_step: assert property (@(posedge calculate) disable iff (!rst_n)
		(feature_valid == '0) || (&feature_valid));

endmodule

/* rtl/haar_stage_top.sv */
`timescale 1ns/100ps

module haar_stage_top
(
	input	logic	calculate,
	input	logic	rst_n,
	input	logic	pixel_valid,
	input	logic	[haar_geom_pkg::PIXEL_W-1:0] pixel,
	input	logic	[haar_cascade_pkg::NUM_FEATURES-1:0][haar_cascade_pkg::RECTS-1:0]
			[haar_cascade_pkg::CORNERS-1:0][haar_geom_pkg::INDEX_W-1:0] corner_index,
	input	logic	[haar_cascade_pkg::NUM_FEATURES-1:0][haar_cascade_pkg::RECTS-1:0]
			[haar_cascade_pkg::WEIGHT_W-1:0] rect_weight,
	input	logic	[haar_cascade_pkg::NUM_FEATURES-1:0]
			[haar_cascade_pkg::FEATURE_W-1:0] feature_threshold,
	input	logic	[haar_cascade_pkg::NUM_FEATURES-1:0][haar_cascade_pkg::VOTE_W-1:0] left_word,
	input	logic	[haar_cascade_pkg::NUM_FEATURES-1:0][haar_cascade_pkg::VOTE_W-1:0] right_word,
	input	logic	signed [haar_cascade_pkg::STAGE_W-1:0] stage_threshold,
	output	logic	stage_valid,
	output	logic	stage_pass,
	output	logic	signed [haar_cascade_pkg::STAGE_W-1:0] stage_sum
);
	import haar_geom_pkg::*;
	import haar_cascade_pkg::*;

	logic [INTEG_W-1:0] integral [WINDOW_PIXELS];
	logic image_ready;
	logic [NUM_FEATURES-1:0] feature_valid;
	logic [NUM_FEATURES-1:0][VOTE_W-1:0] vote;

	integral_image_builder builder_i
	(
		.calculate	(calculate),
		.rst_n		(rst_n),
		.pixel_valid	(pixel_valid),
		.pixel		(pixel),
		.integral	(integral),
		.image_ready	(image_ready)
	);

	// one evaluator per feature, all started by the same pulse
	for (genvar i = 0; i < NUM_FEATURES; i++)
	begin : g_feature
		haar_feature_eval feature_i
		(
			.calculate		(calculate),
			.rst_n			(rst_n),
			.eval_start		(image_ready),
			.integral		(integral),
			.corner_index		(corner_index[i]),
			.rect_weight		(rect_weight[i]),
			.feature_threshold	(feature_threshold[i]),
			.left_word		(left_word[i]),
			.right_word		(right_word[i]),
			.feature_valid		(feature_valid[i]),
			.vote			(vote[i])
		);
	end

	stage_vote_sum vote_sum_i
	(
		.calculate		(calculate),
		.rst_n			(rst_n),
		.feature_valid		(feature_valid),
		.vote			(vote),
		.stage_threshold	(stage_threshold),
		.stage_valid		(stage_valid),
		.stage_pass		(stage_pass),
		.stage_sum		(stage_sum)
	);

endmodule

/* verification/tb_haar_stage.sv */
`timescale 1ns/100ps

module tb_haar_stage;
	import haar_geom_pkg::*;
	import haar_cascade_pkg::*;

	localparam int TIMEOUT_CYCLES = 16 + 40 * 200 + 100;

	logic calculate;
	logic rst_n;
	logic pixel_valid;
	logic [PIXEL_W-1:0] pixel;
	logic [NUM_FEATURES-1:0][RECTS-1:0][CORNERS-1:0][INDEX_W-1:0] corner_index;
	logic [NUM_FEATURES-1:0][RECTS-1:0][WEIGHT_W-1:0] rect_weight;
	logic [NUM_FEATURES-1:0][FEATURE_W-1:0] feature_threshold;
	logic [NUM_FEATURES-1:0][VOTE_W-1:0] left_word;
	logic [NUM_FEATURES-1:0][VOTE_W-1:0] right_word;
	logic signed [STAGE_W-1:0] stage_threshold;
	logic stage_valid;
	logic stage_pass;
	logic signed [STAGE_W-1:0] stage_sum;

	int seed;
	int cycle = 0;
	int errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int mark;
	int pix [WINDOW_H][WINDOW_W];
	int rect_r0 [NUM_FEATURES][RECTS];
	int rect_c0 [NUM_FEATURES][RECTS];
	int rect_r1 [NUM_FEATURES][RECTS];
	int rect_c1 [NUM_FEATURES][RECTS];
	int exp_sum [$];
	bit exp_pass [$];
	int exp_cycle [$];   // cycle count at which stage_valid is seen

	haar_stage_top dut_i
	(
		.calculate		(calculate),
		.rst_n			(rst_n),
		.pixel_valid		(pixel_valid),
		.pixel			(pixel),
		.corner_index		(corner_index),
		.rect_weight		(rect_weight),
		.feature_threshold	(feature_threshold),
		.left_word		(left_word),
		.right_word		(right_word),
		.stage_threshold	(stage_threshold),
		.stage_valid		(stage_valid),
		.stage_pass		(stage_pass),
		.stage_sum		(stage_sum)
	);

	initial
		calculate = 1'b0;

	always #50 calculate = ~calculate;

	always @(posedge calculate)
	begin
		cycle <= cycle + 1;
		if (cycle == TIMEOUT_CYCLES)
		begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// stage outputs checked on the falling edge
	always @(negedge calculate)
	begin
		if (stage_valid)
		begin
			if (exp_sum.size() == 0)
			begin
				$display("%0t: stage_valid pulsed with no frame outstanding", $time);
				errors++;
			end
			else
			begin
				if (cycle != exp_cycle[0])
				begin
					$display("ERROR %0t: stage_valid at cycle %0d, expected cycle %0d",
						$time, cycle, exp_cycle[0]);
					errors++;
				end
				if (int'(stage_sum) != exp_sum[0])
				begin
					$display("ERROR %0t: stage_sum %0d, expected %0d",
						$time, stage_sum, exp_sum[0]);
					errors++;
				end
				if (stage_pass !== exp_pass[0])
				begin
					$display("ERROR %0t: stage_pass %b, expected %b",
						$time, stage_pass, exp_pass[0]);
					errors++;
				end
				void'(exp_sum.pop_front());
				void'(exp_pass.pop_front());
				void'(exp_cycle.pop_front());
			end
		end
		else if (exp_cycle.size() != 0 && cycle > exp_cycle[0])
		begin
			$display("%0t: stage_valid missing, it was due at cycle %0d", $time, exp_cycle[0]);
			errors++;
			void'(exp_sum.pop_front());
			void'(exp_pass.pop_front());
			void'(exp_cycle.pop_front());
		end
	end

	function automatic int rand_range(input int lo, input int hi);
		int v;
		v = $random(seed);
		rand_range = lo + int'((v & 32'h7fff_ffff) % (hi - lo + 1));
	endfunction

	// sum straight from the pixels without the row and column of corner A
	function automatic int area_sum(input int r0, input int c0, input int r1, input int c1);
		int s;
		s = 0;
		for (int r = r0 + 1; r <= r1; r++)
			for (int c = c0 + 1; c <= c1; c++)
				s += pix[r][c];
		return s;
	endfunction

	function automatic int feature_value(input int f);
		int v;
		v = 0;
		for (int r = 0; r < RECTS; r++)
			v += int'($signed(rect_weight[f][r]))
				* area_sum(rect_r0[f][r], rect_c0[f][r], rect_r1[f][r], rect_c1[f][r]);
		return v;
	endfunction

	function automatic int vote_value(input int f);
		if (feature_value(f) > int'($signed(feature_threshold[f])))
			return int'($signed(right_word[f]));
		return int'($signed(left_word[f]));
	endfunction

	task automatic set_rect(input int f, input int r, input int r0, input int c0,
		input int r1, input int c1);
		rect_r0[f][r] = r0;
		rect_c0[f][r] = c0;
		rect_r1[f][r] = r1;
		rect_c1[f][r] = c1;
		corner_index[f][r][CORNER_A] = INDEX_W'(r0 * WINDOW_W + c0);
		corner_index[f][r][CORNER_B] = INDEX_W'(r0 * WINDOW_W + c1);
		corner_index[f][r][CORNER_C] = INDEX_W'(r1 * WINDOW_W + c0);
		corner_index[f][r][CORNER_D] = INDEX_W'(r1 * WINDOW_W + c1);
	endtask

	task automatic pick_span(input int limit, output int lo, output int hi);
		int a;
		int b;
		a = rand_range(0, limit - 1);
		b = a;
		while (b == a)
			b = rand_range(0, limit - 1);
		lo = (a < b) ? a : b;
		hi = (a < b) ? b : a;
	endtask

	task automatic randomize_config();
		int r0;
		int r1;
		int c0;
		int c1;
		for (int f = 0; f < NUM_FEATURES; f++)
		begin
			for (int r = 0; r < RECTS; r++)
			begin
				pick_span(WINDOW_H, r0, r1);
				pick_span(WINDOW_W, c0, c1);
				set_rect(f, r, r0, c0, r1, c1);
				rect_weight[f][r] = WEIGHT_W'(rand_range(-4, 4));
			end
			feature_threshold[f] = FEATURE_W'(rand_range(-3000, 3000));
			left_word[f] = VOTE_W'(rand_range(-500, 500));
			right_word[f] = VOTE_W'(rand_range(-500, 500));
		end
		stage_threshold = STAGE_W'(rand_range(-1000, 1000));
	endtask

	task automatic fixed_config();
		for (int f = 0; f < NUM_FEATURES; f++)
		begin
			set_rect(f, 0, 0, 0, f + 2, 9);
			set_rect(f, 1, 0, 0, 9, f + 1);
			set_rect(f, 2, 2, 2, 5, 5);
			rect_weight[f] = {WEIGHT_W'(0), WEIGHT_W'(-1), WEIGHT_W'(2)};
			feature_threshold[f] = FEATURE_W'(f * 4000 - 6000);
			left_word[f] = VOTE_W'(-50);
			right_word[f] = VOTE_W'(75 + f);
		end
		stage_threshold = '0;
	endtask

	task automatic fill_pixels(input bit random_fill, input int value);
		for (int r = 0; r < WINDOW_H; r++)
			for (int c = 0; c < WINDOW_W; c++)
				pix[r][c] = random_fill ? rand_range(0, 255) : value;
	endtask

	task automatic drive_pixel(input bit valid, input int value);
		@(posedge calculate);
		#10;
		pixel_valid = valid;
		pixel = PIXEL_W'(value);
	endtask

	task automatic push_expected();
		int total;
		total = 0;
		for (int f = 0; f < NUM_FEATURES; f++)
			total += vote_value(f);
		exp_sum.push_back(total);
		exp_pass.push_back(total >= int'(stage_threshold));
		exp_cycle.push_back(cycle + 5);   // last pixel taken next edge plus 4 edges of latency
	endtask

	task automatic send_frame(input int gap_pct);
		for (int r = 0; r < WINDOW_H; r++)
			for (int c = 0; c < WINDOW_W; c++)
			begin
				while (rand_range(0, 99) < gap_pct)
					drive_pixel(1'b0, 0);
				drive_pixel(1'b1, pix[r][c]);
			end
		push_expected();
	endtask

	task automatic drain();
		drive_pixel(1'b0, 0);
		while (exp_cycle.size() != 0)
			@(posedge calculate);
		repeat (2) @(posedge calculate);
	endtask

	task automatic report_test(input string name, input int errors_at_start);
		if (errors == errors_at_start)
		begin
			tests_passed++;
			$display("test %s: ok", name);
		end
		else
		begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - errors_at_start);
		end
	endtask

	initial
	begin
		seed = 32'h75e58f9b;
		rst_n = 1'b0;
		pixel_valid = 1'b0;
		pixel = '0;
		corner_index = '0;
		rect_weight = '0;
		feature_threshold = '0;
		left_word = '0;
		right_word = '0;
		stage_threshold = '0;

		mark = errors;
		repeat (16) @(posedge calculate);
		#10;
		rst_n = 1'b1;
		repeat (20) drive_pixel(1'b0, 0);
		report_test("quiet after reset", mark);

		mark = errors;
		fixed_config();
		fill_pixels(1'b0, 37);
		send_frame(0);
		drain();
		report_test("constant frame", mark);

		mark = errors;
		for (int n = 0; n < 20; n++)
		begin
			randomize_config();
			fill_pixels(1'b1, 0);
			send_frame(0);
			drain();
		end
		report_test("random frames", mark);

		mark = errors;
		for (int n = 0; n < 8; n++)
		begin
			randomize_config();
			fill_pixels(1'b1, 0);
			send_frame(25);
			drain();
		end
		report_test("frames with gaps", mark);

		// one configuration for six frames with no idle cycle
		mark = errors;
		randomize_config();
		for (int n = 0; n < 6; n++)
		begin
			fill_pixels(1'b1, 0);
			send_frame(0);
		end
		drain();
		report_test("back to back frames", mark);

		mark = errors;
		randomize_config();
		fill_pixels(1'b1, 0);
		rect_weight[0][1] = '0;
		rect_weight[0][2] = '0;
		rect_weight[1][2] = '0;
		rect_weight[2][0] = '0;
		for (int f = 0; f < NUM_FEATURES; f++)
			feature_threshold[f] = FEATURE_W'(feature_value(f) - (f % 2));   // equal on even
		stage_threshold = '0;
		for (int f = 0; f < NUM_FEATURES; f++)
			stage_threshold = stage_threshold + STAGE_W'(vote_value(f));
		send_frame(0);
		drain();
		stage_threshold = stage_threshold + 1'b1;
		send_frame(0);
		drain();
		report_test("threshold edges", mark);

		$display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

/* verilog.f */
rtl/haar_geom_pkg.sv
rtl/haar_cascade_pkg.sv
rtl/integral_image_builder.sv
rtl/haar_feature_eval.sv
rtl/stage_vote_sum.sv
rtl/haar_stage_top.sv
verification/tb_haar_stage.sv

/* run_sim.sh */
#!/bin/sh
# build and run the Haar stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f verilog.f --top-module tb_haar_stage -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vtb_haar_stage > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "\*\*\* TEST FAILED \*\*\*" sim.log; then
	echo "simulation reported failure"
	exit 1
fi

exit 0
